// File: Bender.yml
package:
  name: wh_mem

sources:
  - common/wh_pkg.sv
  - common/mem_pkg.sv
  - wh_mem/wh_mem_ctrl.sv
  - wh_mem/wh_mem_array.sv
  - rtl/wh_mem_csr.sv
  - rtl/wh_mem_top.sv
  - target: simulation
    files:
      - sim/wh_mem_tb.sv

// File: build.f
common/wh_pkg.sv
common/mem_pkg.sv
wh_mem/wh_mem_ctrl.sv
wh_mem/wh_mem_array.sv
rtl/wh_mem_csr.sv
rtl/wh_mem_top.sv
sim/wh_mem_tb.sv

// File: common/mem_pkg.sv
`default_nettype none

package mem_pkg;

  // One block is four data flits, one flit per word
  localparam int block_flits        = 4;
  localparam int count_width        = $clog2(block_flits);
  localparam int block_offset_width = 4;

  // One region per cache, selected by the low bits of the source coordinate
  localparam int num_regions    = 2;
  localparam int region_width   = $clog2(num_regions);
  localparam int set_width      = 3;
  localparam int mem_words      = num_regions * (2 ** set_width) * block_flits;
  localparam int mem_addr_width = region_width + set_width + count_width;

  typedef enum logic [2:0] {
    RESET,
    READY,
    RECV_ADDR,
    RECV_EVICT_DATA,
    SEND_FILL_HEADER,
    SEND_FILL_DATA
  } mem_state_e;

  localparam int csr_width = 16;

  typedef enum logic [1:0] {
    CSR_ENABLE = 2'd0,
    CSR_WRITES = 2'd1,
    CSR_READS  = 2'd2
  } csr_addr_e;

endpackage

`default_nettype wire

// File: common/wh_pkg.sv
`default_nettype none

package wh_pkg;

  // Link and flit geometry
  localparam int flit_width = 32;
  localparam int cord_width = 4;
  localparam int cid_width  = 2;
  localparam int len_width  = 4;

  localparam int header_unused_width =
    flit_width - 1 - (2 * cord_width) - cid_width - len_width;

  // Header flit, packed from the most significant end
  typedef struct packed {
    logic [header_unused_width-1:0] unused;
    logic                           write_not_read;
    logic [cord_width-1:0]          src_cord;
    logic [cid_width-1:0]           cid;
    logic [len_width-1:0]           len;
    logic [cord_width-1:0]          dest_cord;
  } wh_header_s;

endpackage

`default_nettype wire

// File: rtl/wh_mem_csr.sv
`timescale 1ns/1ns
`default_nettype none

module wh_mem_csr (
  input  logic                          clk_i,
  input  logic                          reset_i,

  input  logic                          cfg_we_i,
  input  mem_pkg::csr_addr_e            cfg_addr_i,
  input  logic [mem_pkg::csr_width-1:0] cfg_wdata_i,
  output logic [mem_pkg::csr_width-1:0] cfg_rdata_o,

  input  logic                          write_done_i,
  input  logic                          read_done_i,
  output logic                          enable_o
);

  logic                          enable_r;
  logic [mem_pkg::csr_width-1:0] writes_r;
  logic [mem_pkg::csr_width-1:0] reads_r;

  // Only the enable register is writable, counters ignore writes
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      enable_r <= 1'b1;
    end else if (cfg_we_i && (cfg_addr_i == mem_pkg::CSR_ENABLE)) begin
      enable_r <= cfg_wdata_i[0];
    end
  end

  // Packet counters simply wrap
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      writes_r <= '0;
      reads_r  <= '0;
    end else begin
      if (write_done_i) begin
        writes_r <= writes_r + 1'b1;
      end
      if (read_done_i) begin
        reads_r <= reads_r + 1'b1;
      end
    end
  end

  always_comb begin
    case (cfg_addr_i)
      mem_pkg::CSR_ENABLE: cfg_rdata_o = {{(mem_pkg::csr_width-1){1'b0}}, enable_r};
      mem_pkg::CSR_WRITES: cfg_rdata_o = writes_r;
      mem_pkg::CSR_READS:  cfg_rdata_o = reads_r;
      default:             cfg_rdata_o = '0;
    endcase
  end

  assign enable_o = enable_r;

endmodule

`default_nettype wire

// File: rtl/wh_mem_top.sv
`timescale 1ns/1ns
`default_nettype none

module wh_mem_top (
  input  logic                          clk_i,
  input  logic                          reset_i,

  input  logic                          link_v_i,
  input  logic [wh_pkg::flit_width-1:0] link_data_i,
  output logic                          link_ready_o,

  output logic                          link_v_o,
  output logic [wh_pkg::flit_width-1:0] link_data_o,
  input  logic                          link_ready_i,

  input  logic                          cfg_we_i,
  input  mem_pkg::csr_addr_e            cfg_addr_i,
  input  logic [mem_pkg::csr_width-1:0] cfg_wdata_i,
  output logic [mem_pkg::csr_width-1:0] cfg_rdata_o
);

  logic                               enable;
  logic                               write_done;
  logic                               read_done;

  logic                               mem_we;
  logic [mem_pkg::mem_addr_width-1:0] mem_waddr;
  logic [mem_pkg::mem_addr_width-1:0] mem_raddr;
  logic [wh_pkg::flit_width-1:0]      mem_wdata;
  logic [wh_pkg::flit_width-1:0]      mem_rdata;

  wh_mem_ctrl ctrl_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .link_v_i     (link_v_i),
    .link_data_i  (link_data_i),
    .link_ready_o (link_ready_o),
    .link_v_o     (link_v_o),
    .link_data_o  (link_data_o),
    .link_ready_i (link_ready_i),
    .enable_i     (enable),
    .mem_we_o     (mem_we),
    .mem_waddr_o  (mem_waddr),
    .mem_raddr_o  (mem_raddr),
    .mem_wdata_o  (mem_wdata),
    .mem_rdata_i  (mem_rdata),
    .write_done_o (write_done),
    .read_done_o  (read_done)
  );

  wh_mem_array array_i (
    .clk_i   (clk_i),
    .we_i    (mem_we),
    .waddr_i (mem_waddr),
    .raddr_i (mem_raddr),
    .wdata_i (mem_wdata),
    .rdata_o (mem_rdata)
  );

  wh_mem_csr csr_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .cfg_we_i     (cfg_we_i),
    .cfg_addr_i   (cfg_addr_i),
    .cfg_wdata_i  (cfg_wdata_i),
    .cfg_rdata_o  (cfg_rdata_o),
    .write_done_i (write_done),
    .read_done_i  (read_done),
    .enable_o     (enable)
  );

endmodule

`default_nettype wire

// File: sim/wh_mem_tb.sv
`timescale 1ns/1ns
`default_nettype none

module wh_mem_tb;

  localparam int num_packets = 54;
  localparam int cycle_limit = num_packets * 40 + 200;

  logic                          clk_i;
  logic                          reset_i;
  logic                          link_v_i;
  logic [wh_pkg::flit_width-1:0] link_data_i;
  logic                          link_ready_o;
  logic                          link_v_o;
  logic [wh_pkg::flit_width-1:0] link_data_o;
  logic                          link_ready_i;
  logic                          cfg_we_i;
  mem_pkg::csr_addr_e            cfg_addr_i;
  logic [mem_pkg::csr_width-1:0] cfg_wdata_i;
  logic [mem_pkg::csr_width-1:0] cfg_rdata_o;

  logic [31:0] rng;
  logic [31:0] model_mem [int];
  logic [3:0]  written_src [$];
  logic [31:0] written_addr [$];
  int          writes_model;
  int          reads_model;
  int          errors;
  int          test_errors;
  int          tests;
  int          cycles;
  string       test_name;

  wh_mem_top dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  initial begin
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("** FAIL **");
    $finish;
  end

  function automatic logic [31:0] xorshift_next();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // Region from the source coordinate, then block index, then flit
  function automatic int word_addr(logic [3:0] src, logic [31:0] addr, int flit);
    int set_idx;
    set_idx = addr[mem_pkg::block_offset_width +: mem_pkg::set_width];
    return ((src[0] * (2 ** mem_pkg::set_width)) + set_idx) * mem_pkg::block_flits + flit;
  endfunction

  function automatic wh_pkg::wh_header_s make_header(logic wnr, logic [3:0] src,
                                                      logic [1:0] cid);
    wh_pkg::wh_header_s h;
    h                = '0;
    h.write_not_read = wnr;
    h.src_cord       = src;
    h.cid            = cid;
    h.len            = mem_pkg::block_flits;
    return h;
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("CHECK FAILED %s %s: expected %h actual %h", test_name, what, expected, actual);
      errors++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = errors;
  endtask

  task automatic end_test();
    tests++;
    $display("test %s finished with %0d errors", test_name, errors - test_errors);
  endtask

  task automatic send_flit(input logic [31:0] flit);
    @(negedge clk_i);
    link_v_i    = 1'b1;
    link_data_i = flit;
    #1;
    while (!link_ready_o) begin
      @(negedge clk_i);
      #1;
    end
    @(posedge clk_i);
  endtask

  // Holds the last stalled value to see that the outbound flit does not move
  task automatic recv_flit(output logic [31:0] data, input bit bp);
    logic [31:0] r;
    logic [31:0] held;
    bit          stalled;
    bit          done;
    stalled = 0;
    done    = 0;
    while (!done) begin
      @(negedge clk_i);
      link_v_i = 1'b0;
      r = xorshift_next();
      link_ready_i = bp ? (r[1:0] != 2'b00) : 1'b1;
      #1;
      // The response never pauses, so valid stays high until the last flit transfers
      check_value("fill valid timing", 1, link_v_o);
      if (link_v_o) begin
        if (stalled) begin
          check_value("stalled data", held, link_data_o);
        end
        if (link_ready_i) begin
          data = link_data_o;
          done = 1;
        end else begin
          stalled = 1;
          held    = link_data_o;
        end
      end
    end
    @(posedge clk_i);
  endtask

  task automatic write_packet(input logic [3:0] src, input logic [1:0] cid,
                              input logic [31:0] addr);
    logic [31:0] data;
    send_flit(make_header(1'b1, src, cid));
    send_flit(addr);
    for (int i = 0; i < mem_pkg::block_flits; i++) begin
      data = xorshift_next();
      model_mem[word_addr(src, addr, i)] = data;
      send_flit(data);
    end
    @(negedge clk_i);
    link_v_i = 1'b0;
    #1;
    check_value("ready after write", 1, link_ready_o);
    writes_model++;
    written_src.push_back(src);
    written_addr.push_back(addr);
  endtask

  task automatic read_packet(input logic [3:0] src, input logic [1:0] cid,
                             input logic [31:0] addr, input bit bp);
    wh_pkg::wh_header_s fill;
    logic [31:0]        data;
    send_flit(make_header(1'b0, src, cid));
    send_flit(addr);
    recv_flit(fill, bp);
    check_value("fill dest_cord", src, fill.dest_cord);
    check_value("fill cid", cid, fill.cid);
    check_value("fill len", mem_pkg::block_flits, fill.len);
    for (int i = 0; i < mem_pkg::block_flits; i++) begin
      recv_flit(data, bp);
      check_value($sformatf("fill data %0d", i), model_mem[word_addr(src, addr, i)], data);
    end
    reads_model++;
  endtask

  task automatic csr_write(input mem_pkg::csr_addr_e addr, input logic [15:0] value);
    @(negedge clk_i);
    cfg_we_i    = 1'b1;
    cfg_addr_i  = addr;
    cfg_wdata_i = value;
    @(negedge clk_i);
    cfg_we_i = 1'b0;
  endtask

  task automatic csr_read(input mem_pkg::csr_addr_e addr, output logic [15:0] value);
    @(negedge clk_i);
    cfg_addr_i = addr;
    #1;
    value = cfg_rdata_o;
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] addr;
    logic [15:0] val;
    logic [3:0]  src;
    bit          ready_seen;
    int          idx;
    rng          = 32'd34;
    errors       = 0;
    tests        = 0;
    writes_model = 0;
    reads_model  = 0;
    reset_i      = 1'b1;
    link_v_i     = 1'b0;
    link_data_i  = '0;
    link_ready_i = 1'b1;
    cfg_we_i     = 1'b0;
    cfg_addr_i   = mem_pkg::CSR_ENABLE;
    cfg_wdata_i  = '0;
    repeat (2) @(posedge clk_i);

    begin_test("reset");
    @(negedge clk_i);
    reset_i = 1'b0;
    #1;
    check_value("link_v_o", 0, link_v_o);
    ready_seen = 0;
    repeat (2) begin
      @(negedge clk_i);
      #1;
      if (link_ready_o) ready_seen = 1;
    end
    check_value("link_ready_o", 1, ready_seen);
    csr_read(mem_pkg::CSR_ENABLE, val);
    check_value("enable", 1, val);
    csr_read(mem_pkg::CSR_WRITES, val);
    check_value("writes", 0, val);
    csr_read(mem_pkg::CSR_READS, val);
    check_value("reads", 0, val);
    end_test();

    begin_test("write_read");
    repeat (20) begin
      r    = xorshift_next();
      addr = xorshift_next();
      write_packet(r[3:0], r[5:4], addr);
      read_packet(r[3:0], r[7:6], addr, 1'b0);
    end
    end_test();

    begin_test("regions");
    r    = xorshift_next();
    addr = xorshift_next();
    src  = r[3:0];
    write_packet(src, r[5:4], addr);
    write_packet(src ^ 4'd1, r[7:6], addr);
    read_packet(src, r[9:8], addr, 1'b0);
    read_packet(src ^ 4'd1, r[11:10], addr, 1'b0);
    end_test();

    begin_test("back_pressure");
    repeat (8) begin
      r   = xorshift_next();
      idx = r % written_src.size();
      read_packet(written_src[idx], r[21:20], written_addr[idx], 1'b1);
    end
    end_test();

    // A header waits at the link while the memory is disabled
    begin_test("enable");
    r    = xorshift_next();
    addr = xorshift_next();
    csr_write(mem_pkg::CSR_ENABLE, 16'd0);
    csr_read(mem_pkg::CSR_ENABLE, val);
    check_value("enable off", 0, val);
    repeat (6) begin
      @(negedge clk_i);
      link_v_i    = 1'b1;
      link_data_i = make_header(1'b1, r[3:0], r[5:4]);
      #1;
      check_value("ready while disabled", 0, link_ready_o);
    end
    @(negedge clk_i);
    link_v_i = 1'b0;
    csr_write(mem_pkg::CSR_ENABLE, 16'd1);
    write_packet(r[3:0], r[5:4], addr);
    read_packet(r[3:0], r[7:6], addr, 1'b0);
    end_test();

    begin_test("counters");
    repeat (3) @(negedge clk_i);
    csr_read(mem_pkg::CSR_WRITES, val);
    check_value("writes", writes_model[15:0], val);
    csr_read(mem_pkg::CSR_READS, val);
    check_value("reads", reads_model[15:0], val);
    end_test();

    $display("%0d tests run, %0d checks failed", tests, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: wh_mem/wh_mem_array.sv
`timescale 1ns/1ns
`default_nettype none

module wh_mem_array (
  input  logic                               clk_i,
  input  logic                               we_i,
  input  logic [mem_pkg::mem_addr_width-1:0] waddr_i,
  input  logic [mem_pkg::mem_addr_width-1:0] raddr_i,
  input  logic [wh_pkg::flit_width-1:0]      wdata_i,
  output logic [wh_pkg::flit_width-1:0]      rdata_o
);

  logic [wh_pkg::flit_width-1:0] mem_r [mem_pkg::mem_words];

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_r[waddr_i] <= wdata_i;
    end
  end

  // Fill data is read in the same cycle it goes out on the link
  assign rdata_o = mem_r[raddr_i];

endmodule

`default_nettype wire

// File: wh_mem/wh_mem_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module wh_mem_ctrl (
  input  logic                               clk_i,
  input  logic                               reset_i,

  input  logic                               link_v_i,
  input  logic [wh_pkg::flit_width-1:0]      link_data_i,
  output logic                               link_ready_o,

  output logic                               link_v_o,
  output logic [wh_pkg::flit_width-1:0]      link_data_o,
  input  logic                               link_ready_i,

  input  logic                               enable_i,

  output logic                               mem_we_o,
  output logic [mem_pkg::mem_addr_width-1:0] mem_waddr_o,
  output logic [mem_pkg::mem_addr_width-1:0] mem_raddr_o,
  output logic [wh_pkg::flit_width-1:0]      mem_wdata_o,
  input  logic [wh_pkg::flit_width-1:0]      mem_rdata_i,

  output logic                               write_done_o,
  output logic                               read_done_o
);

  mem_pkg::mem_state_e state_r;
  mem_pkg::mem_state_e state_n;

  wh_pkg::wh_header_s header_in;
  wh_pkg::wh_header_s header_out;

  // Fields kept from the request for the rest of the packet
  logic                            write_not_read_r;
  logic [wh_pkg::cord_width-1:0]   src_cord_r;
  logic [wh_pkg::cid_width-1:0]    cid_r;
  logic [mem_pkg::set_width-1:0]   set_r;

  logic [mem_pkg::count_width-1:0] count_r;
  logic                            last_flit;
  logic                            in_fire;
  logic                            out_fire;
  logic                            evict_fire;
  logic                            fill_fire;

  logic [mem_pkg::mem_addr_width-1:0] mem_addr;

  assign header_in = link_data_i;

  assign in_fire    = link_v_i & link_ready_o;
  assign out_fire   = link_v_o & link_ready_i;
  assign evict_fire = (state_r == mem_pkg::RECV_EVICT_DATA) & in_fire;
  assign fill_fire  = (state_r == mem_pkg::SEND_FILL_DATA) & out_fire;
  assign last_flit  = (count_r == mem_pkg::count_width'(mem_pkg::block_flits - 1));

  // Word address is region, block index, then flit within the block
  assign mem_addr = {
    src_cord_r[mem_pkg::region_width-1:0],
    set_r,
    count_r
  };

  assign mem_waddr_o = mem_addr;
  assign mem_raddr_o = mem_addr;
  assign mem_wdata_o = link_data_i;

  // Fill header goes back to the requester
  assign header_out.unused         = '0;
  assign header_out.write_not_read = 1'b0;
  assign header_out.src_cord       = '0;
  assign header_out.cid            = cid_r;
  assign header_out.len            = wh_pkg::len_width'(mem_pkg::block_flits);
  assign header_out.dest_cord      = src_cord_r;

  always_comb begin
    state_n      = state_r;
    link_ready_o = 1'b0;
    link_v_o     = 1'b0;
    link_data_o  = mem_rdata_i;
    mem_we_o     = 1'b0;

    case (state_r)
      mem_pkg::RESET: begin
        state_n = mem_pkg::READY;
      end

      // A disabled memory only refuses new packets
      mem_pkg::READY: begin
        link_ready_o = enable_i;
        if (link_v_i && enable_i) begin
          state_n = mem_pkg::RECV_ADDR;
        end
      end

      mem_pkg::RECV_ADDR: begin
        link_ready_o = 1'b1;
        if (link_v_i) begin
          state_n = write_not_read_r ? mem_pkg::RECV_EVICT_DATA : mem_pkg::SEND_FILL_HEADER;
        end
      end

      mem_pkg::RECV_EVICT_DATA: begin
        link_ready_o = 1'b1;
        if (link_v_i) begin
          mem_we_o = 1'b1;
          if (last_flit) begin
            state_n = mem_pkg::READY;
          end
        end
      end

      mem_pkg::SEND_FILL_HEADER: begin
        link_v_o    = 1'b1;
        link_data_o = header_out;
        if (link_ready_i) begin
          state_n = mem_pkg::SEND_FILL_DATA;
        end
      end

      // Read address only moves on a transfer, so stalled data stays put
      mem_pkg::SEND_FILL_DATA: begin
        link_v_o = 1'b1;
        if (link_ready_i && last_flit) begin
          state_n = mem_pkg::READY;
        end
      end

      default: begin
        state_n = mem_pkg::RESET;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r      <= mem_pkg::RESET;
      count_r      <= '0;
      write_done_o <= 1'b0;
      read_done_o  <= 1'b0;
    end else begin
      state_r      <= state_n;
      write_done_o <= evict_fire & last_flit;
      read_done_o  <= fill_fire & last_flit;
      if (evict_fire || fill_fire) begin
        count_r <= last_flit ? '0 : count_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_r == mem_pkg::READY) && in_fire) begin
      write_not_read_r <= header_in.write_not_read;
      src_cord_r       <= header_in.src_cord;
      cid_r            <= header_in.cid;
    end
    if ((state_r == mem_pkg::RECV_ADDR) && in_fire) begin
      set_r <= link_data_i[mem_pkg::block_offset_width +: mem_pkg::set_width];
    end
  end

endmodule

`default_nettype wire
